/* rtl/rv_isa_pkg.sv */
////////////////////////////////////////
// RV32I instruction set definitions
// opcode, funct3 and funct7 field codes for the
// supported subset, full-word system encodings
// and the first fetch address
////////////////////////////////////////
package rv_isa_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [6:0] opcode_t;

	// major opcodes
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_JALR = 3'b000;

	// loads and stores
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;

	// immediate operations, srli and srai share funct3
	localparam logic [2:0] F3_ADDI  = 3'b000;
	localparam logic [2:0] F3_SLLI  = 3'b001;
	localparam logic [2:0] F3_SLTI  = 3'b010;
	localparam logic [2:0] F3_SLTIU = 3'b011;
	localparam logic [2:0] F3_XORI  = 3'b100;
	localparam logic [2:0] F3_SRI   = 3'b101;
	localparam logic [2:0] F3_ORI   = 3'b110;
	localparam logic [2:0] F3_ANDI  = 3'b111;
	localparam logic [6:0] F7_BASE  = 7'b0000000;
	localparam logic [6:0] F7_SRA   = 7'b0100000;

	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;

	localparam inst_t INST_ECALL  = 32'h0000_0073;
	localparam inst_t INST_EBREAK = 32'h0010_0073;
	localparam inst_t INST_MRET   = 32'h3020_0073;

	localparam addr_t RESET_PC = 32'h0000_0000;

endpackage

/* rtl/mem_bus_pkg.sv */
////////////////////////////////////////
// memory bus definitions
// request and response channel structs,
// response codes, arbiter owner and the
// fetch state encoding shared with checks
////////////////////////////////////////
package mem_bus_pkg;

	typedef logic [31:0] data_t;

	// memory depth in words
	localparam int MEM_WORDS = 256;
	localparam int MEM_AW    = $clog2(MEM_WORDS);

	typedef logic [1:0] resp_t;
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic              valid;
		logic              write;
		rv_isa_pkg::addr_t addr;
		data_t             wdata;
	} bus_req_t;

	typedef struct packed {
		logic  valid;
		data_t rdata;
		resp_t resp;
	} bus_rsp_t;

	typedef enum logic {
		OWNER_IFU,
		OWNER_LSU
	} owner_t;

	typedef enum logic [1:0] {
		ADDR,
		LOAD,
		READY,
		FINISH
	} ifu_state_t;

endpackage

/* rtl/inst_legal_chk.sv */
////////////////////////////////////////
// legality check of one instruction word
// against the supported RV32I subset
// purely combinational, high means illegal
////////////////////////////////////////
`timescale 1ns/1ns

module inst_legal_chk (
	input  rv_isa_pkg::inst_t inst_i,
	output logic              illegal_o
);

	rv_isa_pkg::opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic legal;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	always_comb begin
		legal = 1'b0;
		case (opcode)
			rv_isa_pkg::OPC_LUI,
			rv_isa_pkg::OPC_AUIPC,
			rv_isa_pkg::OPC_JAL,
			rv_isa_pkg::OPC_BRANCH,
			rv_isa_pkg::OPC_OP: legal = 1'b1;
			rv_isa_pkg::OPC_JALR: legal = (funct3 == rv_isa_pkg::F3_JALR);
			rv_isa_pkg::OPC_LOAD: legal = funct3 inside {rv_isa_pkg::F3_LB, rv_isa_pkg::F3_LH,
				rv_isa_pkg::F3_LW, rv_isa_pkg::F3_LBU, rv_isa_pkg::F3_LHU};
			rv_isa_pkg::OPC_STORE: legal = funct3 inside {rv_isa_pkg::F3_SB,
				rv_isa_pkg::F3_SH, rv_isa_pkg::F3_SW};
			rv_isa_pkg::OPC_OP_IMM: begin
				case (funct3)
					rv_isa_pkg::F3_ADDI,
					rv_isa_pkg::F3_SLTI,
					rv_isa_pkg::F3_SLTIU,
					rv_isa_pkg::F3_XORI,
					rv_isa_pkg::F3_ORI,
					rv_isa_pkg::F3_ANDI: legal = 1'b1;
					// shifts carry funct7 in the upper immediate bits
					rv_isa_pkg::F3_SLLI: legal = (funct7 == rv_isa_pkg::F7_BASE);
					rv_isa_pkg::F3_SRI: legal = (funct7 == rv_isa_pkg::F7_BASE) ||
						(funct7 == rv_isa_pkg::F7_SRA);
					default: legal = 1'b0;
				endcase
			end
			rv_isa_pkg::OPC_SYSTEM: legal = (funct3 == rv_isa_pkg::F3_CSRRW) ||
				(funct3 == rv_isa_pkg::F3_CSRRS) ||
				(inst_i == rv_isa_pkg::INST_ECALL) ||
				(inst_i == rv_isa_pkg::INST_EBREAK) ||
				(inst_i == rv_isa_pkg::INST_MRET);
			default: legal = 1'b0;
		endcase
	end

	assign illegal_o = ~legal;

endmodule

/* rtl/fetch_unit.sv */
////////////////////////////////////////
// instruction fetch unit
// keeps the pc, reads one word per step over
// the memory bus and presents it for a cycle,
// then waits for the core to finish before
// moving on to pc+4 or a redirect target
////////////////////////////////////////
`timescale 1ns/1ns

module fetch_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  last_finish_i,
	input  logic                  branch_taken_i,
	input  rv_isa_pkg::addr_t     branch_target_i,
	input  logic                  jump_i,
	input  rv_isa_pkg::addr_t     jump_target_i,
	input  logic                  trap_i,
	input  rv_isa_pkg::addr_t     trap_pc_i,
	output mem_bus_pkg::bus_req_t bus_req_o,
	input  logic                  bus_ready_i,
	input  mem_bus_pkg::bus_rsp_t bus_rsp_i,
	output logic                  bus_rsp_ready_o,
	output logic                  inst_valid_o,
	output rv_isa_pkg::inst_t     inst_o,
	output rv_isa_pkg::addr_t     pc_o,
	output logic                  inst_illegal_o,
	output logic                  inst_fault_o
);

	mem_bus_pkg::ifu_state_t state_q;
	mem_bus_pkg::ifu_state_t state_d;
	rv_isa_pkg::addr_t pc_q;
	rv_isa_pkg::addr_t pc_next;
	rv_isa_pkg::addr_t inst_pc_q;
	rv_isa_pkg::inst_t inst_q;
	logic req_valid_q;
	logic inst_valid_q;
	logic fault_q;
	logic word_illegal;
	logic req_fire;
	logic rsp_fire;
	logic rsp_err;

	assign req_fire = req_valid_q & bus_ready_i;
	assign bus_rsp_ready_o = (state_q == mem_bus_pkg::LOAD);
	assign rsp_fire = bus_rsp_i.valid & bus_rsp_ready_o;
	assign rsp_err = (bus_rsp_i.resp == mem_bus_pkg::RESP_SLVERR);

	// read request always targets the current pc
	always_comb begin
		bus_req_o = '0;
		bus_req_o.valid = req_valid_q;
		bus_req_o.addr = pc_q;
	end

	// trap beats jump beats branch
	always_comb begin
		if (trap_i)
			pc_next = trap_pc_i;
		else if (jump_i)
			pc_next = jump_target_i;
		else if (branch_taken_i)
			pc_next = branch_target_i;
		else
			pc_next = pc_q + 32'd4;
	end

	always_comb begin
		case (state_q)
			mem_bus_pkg::ADDR: state_d = req_fire ? mem_bus_pkg::LOAD : mem_bus_pkg::ADDR;
			mem_bus_pkg::LOAD: state_d = rsp_fire ? mem_bus_pkg::READY : mem_bus_pkg::LOAD;
			mem_bus_pkg::READY: state_d = mem_bus_pkg::FINISH;
			mem_bus_pkg::FINISH: state_d = last_finish_i ? mem_bus_pkg::ADDR : mem_bus_pkg::FINISH;
			default: state_d = mem_bus_pkg::ADDR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= mem_bus_pkg::ADDR;
			pc_q <= rv_isa_pkg::RESET_PC;
			req_valid_q <= 1'b0;
			inst_valid_q <= 1'b0;
			fault_q <= 1'b0;
		end else begin
			state_q <= state_d;
			inst_valid_q <= (state_q == mem_bus_pkg::READY);
			if (req_fire)
				req_valid_q <= 1'b0;
			else if (state_q == mem_bus_pkg::ADDR)
				req_valid_q <= 1'b1;
			// next request goes out right after the finish handshake
			if (state_q == mem_bus_pkg::FINISH && last_finish_i) begin
				pc_q <= pc_next;
				req_valid_q <= 1'b1;
			end
			if (rsp_fire)
				fault_q <= rsp_err;
		end
	end

	// captured word and its pc hold until the next capture
	always_ff @(posedge clk) begin
		if (rsp_fire) begin
			inst_q <= rsp_err ? '0 : bus_rsp_i.rdata;
			inst_pc_q <= pc_q;
		end
	end

	inst_legal_chk legal_chk_i (
		.inst_i    (inst_q),
		.illegal_o (word_illegal)
	);

	assign inst_valid_o = inst_valid_q;
	assign inst_o = inst_q;
	assign pc_o = inst_pc_q;
	assign inst_fault_o = fault_q;
	assign inst_illegal_o = word_illegal & ~fault_q;

endmodule

/* rtl/load_store_unit.sv */
////////////////////////////////////////
// single-word load/store unit
// a strobe on req_i starts one bus access,
// done_o pulses once the response is back
////////////////////////////////////////
`timescale 1ns/1ns

module load_store_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req_i,
	input  logic                  we_i,
	input  rv_isa_pkg::addr_t     addr_i,
	input  mem_bus_pkg::data_t    wdata_i,
	output mem_bus_pkg::bus_req_t bus_req_o,
	input  logic                  bus_ready_i,
	input  mem_bus_pkg::bus_rsp_t bus_rsp_i,
	output logic                  bus_rsp_ready_o,
	output logic                  done_o,
	output mem_bus_pkg::data_t    rdata_o,
	output logic                  err_o
);

	logic busy_q;
	logic req_valid_q;
	logic done_q;
	logic err_q;
	logic op_write_q;
	rv_isa_pkg::addr_t op_addr_q;
	mem_bus_pkg::data_t op_wdata_q;
	mem_bus_pkg::data_t rdata_q;
	logic start;
	logic rsp_fire;

	// strobes while busy are dropped
	assign start = req_i & ~busy_q;
	assign rsp_fire = busy_q & bus_rsp_i.valid;
	assign bus_rsp_ready_o = busy_q;

	always_comb begin
		bus_req_o.valid = req_valid_q;
		bus_req_o.write = op_write_q;
		bus_req_o.addr = op_addr_q;
		bus_req_o.wdata = op_wdata_q;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			req_valid_q <= 1'b0;
			done_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (start) begin
				busy_q <= 1'b1;
				req_valid_q <= 1'b1;
			end else if (req_valid_q && bus_ready_i) begin
				req_valid_q <= 1'b0;
			end else if (rsp_fire) begin
				busy_q <= 1'b0;
				done_q <= 1'b1;
				err_q <= (bus_rsp_i.resp == mem_bus_pkg::RESP_SLVERR);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			op_write_q <= we_i;
			op_addr_q <= addr_i;
			op_wdata_q <= wdata_i;
		end
		if (rsp_fire && !op_write_q)
			rdata_q <= bus_rsp_i.rdata;
	end

	assign done_o = done_q;
	assign rdata_o = rdata_q;
	assign err_o = err_q;

endmodule

/* rtl/bus_arbiter.sv */
////////////////////////////////////////
// two-master round-robin bus arbiter
// grants while idle, then stays locked to the
// owner until its response handshake is done
////////////////////////////////////////
`timescale 1ns/1ns

module bus_arbiter (
	input  logic                  clk,
	input  logic                  rst,
	input  mem_bus_pkg::bus_req_t ifu_req_i,
	output logic                  ifu_ready_o,
	output mem_bus_pkg::bus_rsp_t ifu_rsp_o,
	input  logic                  ifu_rsp_ready_i,
	input  mem_bus_pkg::bus_req_t lsu_req_i,
	output logic                  lsu_ready_o,
	output mem_bus_pkg::bus_rsp_t lsu_rsp_o,
	input  logic                  lsu_rsp_ready_i,
	output mem_bus_pkg::bus_req_t mem_req_o,
	input  logic                  mem_ready_i,
	input  mem_bus_pkg::bus_rsp_t mem_rsp_i,
	output logic                  mem_rsp_ready_o
);

	logic locked_q;
	// current owner while locked, last grant while idle
	mem_bus_pkg::owner_t owner_q;
	mem_bus_pkg::owner_t sel;
	mem_bus_pkg::bus_req_t sel_req;
	logic owner_rsp_ready;
	logic grant_fire;
	logic rsp_done;

	always_comb begin
		if (ifu_req_i.valid && lsu_req_i.valid)
			sel = (owner_q == mem_bus_pkg::OWNER_IFU) ? mem_bus_pkg::OWNER_LSU :
				mem_bus_pkg::OWNER_IFU;
		else if (lsu_req_i.valid)
			sel = mem_bus_pkg::OWNER_LSU;
		else
			sel = mem_bus_pkg::OWNER_IFU;
	end

	assign sel_req = (sel == mem_bus_pkg::OWNER_IFU) ? ifu_req_i : lsu_req_i;

	always_comb begin
		mem_req_o = sel_req;
		if (locked_q)
			mem_req_o.valid = 1'b0;
	end

	assign ifu_ready_o = ~locked_q & (sel == mem_bus_pkg::OWNER_IFU) & mem_ready_i;
	assign lsu_ready_o = ~locked_q & (sel == mem_bus_pkg::OWNER_LSU) & mem_ready_i;
	assign grant_fire = ~locked_q & sel_req.valid & mem_ready_i;

	// response path goes to the owner only
	assign owner_rsp_ready = (owner_q == mem_bus_pkg::OWNER_IFU) ? ifu_rsp_ready_i :
		lsu_rsp_ready_i;
	assign mem_rsp_ready_o = locked_q & owner_rsp_ready;
	assign rsp_done = locked_q & mem_rsp_i.valid & owner_rsp_ready;

	always_comb begin
		ifu_rsp_o = mem_rsp_i;
		lsu_rsp_o = mem_rsp_i;
		ifu_rsp_o.valid = mem_rsp_i.valid & locked_q & (owner_q == mem_bus_pkg::OWNER_IFU);
		lsu_rsp_o.valid = mem_rsp_i.valid & locked_q & (owner_q == mem_bus_pkg::OWNER_LSU);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			locked_q <= 1'b0;
			// fetch wins the first tie
			owner_q <= mem_bus_pkg::OWNER_LSU;
		end else if (grant_fire) begin
			locked_q <= 1'b1;
			owner_q <= sel;
		end else if (rsp_done) begin
			locked_q <= 1'b0;
		end
	end

endmodule

/* rtl/word_sram.sv */
////////////////////////////////////////
// word-addressed memory model
// answers one cycle after accepting a request
// and flags addresses past the array
////////////////////////////////////////
`timescale 1ns/1ns

module word_sram (
	input  logic                  clk,
	input  logic                  rst,
	input  mem_bus_pkg::bus_req_t req_i,
	output logic                  ready_o,
	output mem_bus_pkg::bus_rsp_t rsp_o,
	input  logic                  rsp_ready_i
);

	mem_bus_pkg::data_t mem [mem_bus_pkg::MEM_WORDS];
	logic rsp_valid_q;
	mem_bus_pkg::data_t rsp_data_q;
	mem_bus_pkg::resp_t rsp_code_q;
	logic [mem_bus_pkg::MEM_AW-1:0] idx;
	logic in_range;
	logic accept;

	initial begin
		for (int i = 0; i < mem_bus_pkg::MEM_WORDS; i++)
			mem[i] = '0;
	end

	assign idx = req_i.addr[mem_bus_pkg::MEM_AW+1:2];
	assign in_range = (req_i.addr[31:2] < 30'(mem_bus_pkg::MEM_WORDS));
	assign ready_o = ~rsp_valid_q;
	assign accept = req_i.valid & ready_o;

	always_ff @(posedge clk) begin
		if (rst)
			rsp_valid_q <= 1'b0;
		else if (accept)
			rsp_valid_q <= 1'b1;
		else if (rsp_ready_i)
			rsp_valid_q <= 1'b0;
	end

	// out of range writes are dropped
	always_ff @(posedge clk) begin
		if (accept) begin
			if (req_i.write && in_range)
				mem[idx] <= req_i.wdata;
			rsp_data_q <= in_range ? mem[idx] : '0;
			rsp_code_q <= in_range ? mem_bus_pkg::RESP_OKAY : mem_bus_pkg::RESP_SLVERR;
		end
	end

	assign rsp_o = '{valid: rsp_valid_q, rdata: rsp_data_q, resp: rsp_code_q};

endmodule

/* rtl/fetch_mem_top.sv */
////////////////////////////////////////
// fetch front end with its memory path
// fetch unit and load/store unit share one
// word memory through the bus arbiter
////////////////////////////////////////
`timescale 1ns/1ns

module fetch_mem_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               last_finish_i,
	input  logic               branch_taken_i,
	input  rv_isa_pkg::addr_t  branch_target_i,
	input  logic               jump_i,
	input  rv_isa_pkg::addr_t  jump_target_i,
	input  logic               trap_i,
	input  rv_isa_pkg::addr_t  trap_pc_i,
	output logic               inst_valid_o,
	output rv_isa_pkg::inst_t  inst_o,
	output rv_isa_pkg::addr_t  pc_o,
	output logic               inst_illegal_o,
	output logic               inst_fault_o,
	input  logic               lsu_req_i,
	input  logic               lsu_we_i,
	input  rv_isa_pkg::addr_t  lsu_addr_i,
	input  mem_bus_pkg::data_t lsu_wdata_i,
	output logic               lsu_done_o,
	output mem_bus_pkg::data_t lsu_rdata_o,
	output logic               lsu_err_o
);

	mem_bus_pkg::bus_req_t ifu_req;
	mem_bus_pkg::bus_rsp_t ifu_rsp;
	mem_bus_pkg::bus_req_t lsu_req;
	mem_bus_pkg::bus_rsp_t lsu_rsp;
	mem_bus_pkg::bus_req_t mem_req;
	mem_bus_pkg::bus_rsp_t mem_rsp;
	logic ifu_ready;
	logic ifu_rsp_ready;
	logic lsu_ready;
	logic lsu_rsp_ready;
	logic mem_ready;
	logic mem_rsp_ready;

	fetch_unit fetch_unit_i (
		.clk             (clk),
		.rst             (rst),
		.last_finish_i   (last_finish_i),
		.branch_taken_i  (branch_taken_i),
		.branch_target_i (branch_target_i),
		.jump_i          (jump_i),
		.jump_target_i   (jump_target_i),
		.trap_i          (trap_i),
		.trap_pc_i       (trap_pc_i),
		.bus_req_o       (ifu_req),
		.bus_ready_i     (ifu_ready),
		.bus_rsp_i       (ifu_rsp),
		.bus_rsp_ready_o (ifu_rsp_ready),
		.inst_valid_o    (inst_valid_o),
		.inst_o          (inst_o),
		.pc_o            (pc_o),
		.inst_illegal_o  (inst_illegal_o),
		.inst_fault_o    (inst_fault_o)
	);

	load_store_unit lsu_i (
		.clk             (clk),
		.rst             (rst),
		.req_i           (lsu_req_i),
		.we_i            (lsu_we_i),
		.addr_i          (lsu_addr_i),
		.wdata_i         (lsu_wdata_i),
		.bus_req_o       (lsu_req),
		.bus_ready_i     (lsu_ready),
		.bus_rsp_i       (lsu_rsp),
		.bus_rsp_ready_o (lsu_rsp_ready),
		.done_o          (lsu_done_o),
		.rdata_o         (lsu_rdata_o),
		.err_o           (lsu_err_o)
	);

	bus_arbiter arbiter_i (
		.clk             (clk),
		.rst             (rst),
		.ifu_req_i       (ifu_req),
		.ifu_ready_o     (ifu_ready),
		.ifu_rsp_o       (ifu_rsp),
		.ifu_rsp_ready_i (ifu_rsp_ready),
		.lsu_req_i       (lsu_req),
		.lsu_ready_o     (lsu_ready),
		.lsu_rsp_o       (lsu_rsp),
		.lsu_rsp_ready_i (lsu_rsp_ready),
		.mem_req_o       (mem_req),
		.mem_ready_i     (mem_ready),
		.mem_rsp_i       (mem_rsp),
		.mem_rsp_ready_o (mem_rsp_ready)
	);

	word_sram sram_i (
		.clk         (clk),
		.rst         (rst),
		.req_i       (mem_req),
		.ready_o     (mem_ready),
		.rsp_o       (mem_rsp),
		.rsp_ready_i (mem_rsp_ready)
	);

endmodule

/* sim/tb_clk_gen.sv */
////////////////////////////////////////
// testbench clock and reset source
// 8 ns clock, reset held for 16 cycles
////////////////////////////////////////
`timescale 1ns/1ns

module tb_clk_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (16) @(posedge clk_o);
		#1 rst_o = 1'b0;
	end

endmodule

/* sim/fetch_mem_asserts.sv */
////////////////////////////////////////
// concurrent checks bound into the bus
// arbiter and the fetch unit; each binding
// ties off the inputs it does not use
////////////////////////////////////////
`timescale 1ns/1ns

module fetch_mem_asserts (
	input logic                    clk,
	input logic                    rst,
	input logic                    ifu_req_valid_i,
	input logic                    ifu_ready_i,
	input logic                    ifu_rsp_valid_i,
	input logic                    ifu_rsp_ready_i,
	input logic                    lsu_req_valid_i,
	input logic                    lsu_ready_i,
	input logic                    lsu_rsp_valid_i,
	input logic                    lsu_rsp_ready_i,
	input mem_bus_pkg::bus_req_t   req_i,
	input logic                    req_ready_i,
	input logic                    inst_valid_i,
	input mem_bus_pkg::ifu_state_t state_i,
	input logic                    last_finish_i
);

	int fail_cnt = 0;
	// bus ownership as seen from the handshakes
	logic busy_q;
	logic lsu_own_q;
	// word presented, core not finished yet
	logic finish_wait_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			lsu_own_q <= 1'b0;
		end else if (ifu_req_valid_i && ifu_ready_i) begin
			busy_q <= 1'b1;
			lsu_own_q <= 1'b0;
		end else if (lsu_req_valid_i && lsu_ready_i) begin
			busy_q <= 1'b1;
			lsu_own_q <= 1'b1;
		end else if ((ifu_rsp_valid_i && ifu_rsp_ready_i) ||
			(lsu_rsp_valid_i && lsu_rsp_ready_i)) begin
			busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			finish_wait_q <= 1'b0;
		else if (last_finish_i)
			finish_wait_q <= 1'b0;
		else if (inst_valid_i)
			finish_wait_q <= 1'b1;
	end

	// no new grant while a transaction is open
	ready_busy: assert property (@(posedge clk) disable iff (rst)
		busy_q |-> !ifu_ready_i && !lsu_ready_i)
		else begin
			$error("request ready given while a transaction is open");
			fail_cnt++;
		end

	// responses reach the owner only
	ifu_rsp_owner: assert property (@(posedge clk) disable iff (rst)
		ifu_rsp_valid_i |-> busy_q && !lsu_own_q)
		else begin
			$error("fetch unit got a response it does not own");
			fail_cnt++;
		end

	lsu_rsp_owner: assert property (@(posedge clk) disable iff (rst)
		lsu_rsp_valid_i |-> busy_q && lsu_own_q)
		else begin
			$error("load/store unit got a response it does not own");
			fail_cnt++;
		end

	req_stable: assert property (@(posedge clk) disable iff (rst)
		req_i.valid && !req_ready_i |=> $stable(req_i))
		else begin
			$error("bus request changed before it was accepted");
			fail_cnt++;
		end

	valid_pulse: assert property (@(posedge clk) disable iff (rst)
		inst_valid_i |=> !inst_valid_i)
		else begin
			$error("inst_valid_o longer than one cycle");
			fail_cnt++;
		end

	finish_hold: assert property (@(posedge clk) disable iff (rst)
		finish_wait_q |-> state_i == mem_bus_pkg::FINISH)
		else begin
			$error("fetch unit left FINISH without last_finish_i");
			fail_cnt++;
		end

endmodule

/* sim/fetch_mem_tb.sv */
////////////////////////////////////////
// table-driven testbench for the fetch front end
// each table row is a load/store access, a fetch
// step with a redirect, or both at once; results
// are compared with a memory and pc model
////////////////////////////////////////
`timescale 1ns/1ns

module fetch_mem_tb;

	localparam int DRIVE_DLY = 1;
	localparam int CYCLES_PER_STEP = 40;
	localparam int RESET_CYCLES = 16;

	typedef enum {OP_FIRST, OP_WRITE, OP_READ, OP_FETCH, OP_MIX_RD, OP_MIX_WR} op_e;

	typedef struct {
		string              name;
		op_e                op;
		rv_isa_pkg::addr_t  addr;
		mem_bus_pkg::data_t data;
		logic               rand_data;
		// redirect enables as trap, jump, branch
		logic [2:0]         redir;
		rv_isa_pkg::addr_t  trap_pc;
		rv_isa_pkg::addr_t  jump_pc;
		rv_isa_pkg::addr_t  br_pc;
		logic               illegal;
	} step_t;

	logic clk;
	logic rst;
	logic last_finish_i;
	logic branch_taken_i;
	rv_isa_pkg::addr_t branch_target_i;
	logic jump_i;
	rv_isa_pkg::addr_t jump_target_i;
	logic trap_i;
	rv_isa_pkg::addr_t trap_pc_i;
	logic inst_valid_o;
	rv_isa_pkg::inst_t inst_o;
	rv_isa_pkg::addr_t pc_o;
	logic inst_illegal_o;
	logic inst_fault_o;
	logic lsu_req_i;
	logic lsu_we_i;
	rv_isa_pkg::addr_t lsu_addr_i;
	mem_bus_pkg::data_t lsu_wdata_i;
	logic lsu_done_o;
	mem_bus_pkg::data_t lsu_rdata_o;
	logic lsu_err_o;

	step_t tbl[$];
	mem_bus_pkg::data_t model_mem [mem_bus_pkg::MEM_WORDS];
	rv_isa_pkg::addr_t model_pc;

	tb_clk_gen clk_gen_i (
		.clk_o (clk),
		.rst_o (rst)
	);

	fetch_mem_top dut_i (
		.clk             (clk),
		.rst             (rst),
		.last_finish_i   (last_finish_i),
		.branch_taken_i  (branch_taken_i),
		.branch_target_i (branch_target_i),
		.jump_i          (jump_i),
		.jump_target_i   (jump_target_i),
		.trap_i          (trap_i),
		.trap_pc_i       (trap_pc_i),
		.inst_valid_o    (inst_valid_o),
		.inst_o          (inst_o),
		.pc_o            (pc_o),
		.inst_illegal_o  (inst_illegal_o),
		.inst_fault_o    (inst_fault_o),
		.lsu_req_i       (lsu_req_i),
		.lsu_we_i        (lsu_we_i),
		.lsu_addr_i      (lsu_addr_i),
		.lsu_wdata_i     (lsu_wdata_i),
		.lsu_done_o      (lsu_done_o),
		.lsu_rdata_o     (lsu_rdata_o),
		.lsu_err_o       (lsu_err_o)
	);

	bind bus_arbiter fetch_mem_asserts arb_chk_i (
		.clk             (clk),
		.rst             (rst),
		.ifu_req_valid_i (ifu_req_i.valid),
		.ifu_ready_i     (ifu_ready_o),
		.ifu_rsp_valid_i (ifu_rsp_o.valid),
		.ifu_rsp_ready_i (ifu_rsp_ready_i),
		.lsu_req_valid_i (lsu_req_i.valid),
		.lsu_ready_i     (lsu_ready_o),
		.lsu_rsp_valid_i (lsu_rsp_o.valid),
		.lsu_rsp_ready_i (lsu_rsp_ready_i),
		.req_i           (lsu_req_i),
		.req_ready_i     (lsu_ready_o),
		.inst_valid_i    (1'b0),
		.state_i         (mem_bus_pkg::ADDR),
		.last_finish_i   (1'b0)
	);

	bind fetch_unit fetch_mem_asserts ifu_chk_i (
		.clk             (clk),
		.rst             (rst),
		.ifu_req_valid_i (1'b0),
		.ifu_ready_i     (1'b0),
		.ifu_rsp_valid_i (1'b0),
		.ifu_rsp_ready_i (1'b0),
		.lsu_req_valid_i (1'b0),
		.lsu_ready_i     (1'b0),
		.lsu_rsp_valid_i (1'b0),
		.lsu_rsp_ready_i (1'b0),
		.req_i           (bus_req_o),
		.req_ready_i     (bus_ready_i),
		.inst_valid_i    (inst_valid_o),
		.state_i         (state_q),
		.last_finish_i   (last_finish_i)
	);

	function automatic step_t lsu_step(string name, op_e op, rv_isa_pkg::addr_t addr,
		mem_bus_pkg::data_t data, logic rnd);
		step_t s;
		s.name = name;
		s.op = op;
		s.addr = addr;
		s.data = data;
		s.rand_data = rnd;
		s.redir = 3'b000;
		s.trap_pc = '0;
		s.jump_pc = '0;
		s.br_pc = '0;
		s.illegal = 1'b0;
		return s;
	endfunction

	function automatic step_t fetch_step(string name, logic [2:0] redir,
		rv_isa_pkg::addr_t trap_pc, rv_isa_pkg::addr_t jump_pc, rv_isa_pkg::addr_t br_pc,
		logic illegal);
		step_t s;
		s = lsu_step(name, OP_FETCH, '0, '0, 1'b0);
		s.redir = redir;
		s.trap_pc = trap_pc;
		s.jump_pc = jump_pc;
		s.br_pc = br_pc;
		s.illegal = illegal;
		return s;
	endfunction

	function automatic step_t mix_step(string name, op_e op, rv_isa_pkg::addr_t addr,
		logic illegal);
		step_t s;
		s = lsu_step(name, op, addr, '0, op == OP_MIX_WR);
		s.illegal = illegal;
		return s;
	endfunction

	task automatic build_table();
		step_t s;
		s = fetch_step("first_fetch", 3'b000, '0, '0, '0, 1'b1);
		s.op = OP_FIRST;
		tbl.push_back(s);
		// program words at 0x100, legality noted in the fetch rows below
		tbl.push_back(lsu_step("prog_addi", OP_WRITE, 32'h100, 32'h0050_0093, 1'b0));
		tbl.push_back(lsu_step("prog_lw", OP_WRITE, 32'h104, 32'h0000_a103, 1'b0));
		tbl.push_back(lsu_step("prog_sw", OP_WRITE, 32'h108, 32'h0020_a223, 1'b0));
		tbl.push_back(lsu_step("prog_slli_f7", OP_WRITE, 32'h10c, 32'h4010_9193, 1'b0));
		tbl.push_back(lsu_step("prog_jalr_f3", OP_WRITE, 32'h110, 32'h0000_9067, 1'b0));
		tbl.push_back(lsu_step("prog_ecall", OP_WRITE, 32'h114, 32'h0000_0073, 1'b0));
		tbl.push_back(lsu_step("prog_mret", OP_WRITE, 32'h118, 32'h3020_0073, 1'b0));
		tbl.push_back(lsu_step("prog_bad_opc", OP_WRITE, 32'h11c, 32'hffff_ffff, 1'b0));
		tbl.push_back(lsu_step("prog_srai", OP_WRITE, 32'h120, 32'h4010_d193, 1'b0));
		tbl.push_back(lsu_step("prog_add", OP_WRITE, 32'h124, 32'h0020_81b3, 1'b0));
		tbl.push_back(lsu_step("prog_csrrw", OP_WRITE, 32'h128, 32'h3001_10f3, 1'b0));
		tbl.push_back(lsu_step("prog_ld", OP_WRITE, 32'h12c, 32'h0000_b103, 1'b0));
		// data region and the word just past memory
		tbl.push_back(lsu_step("wr_d0", OP_WRITE, 32'h200, '0, 1'b1));
		tbl.push_back(lsu_step("wr_d1", OP_WRITE, 32'h204, '0, 1'b1));
		tbl.push_back(lsu_step("wr_top", OP_WRITE, 32'h3fc, '0, 1'b1));
		tbl.push_back(lsu_step("wr_oob", OP_WRITE, 32'h400, '0, 1'b1));
		tbl.push_back(lsu_step("rd_d0", OP_READ, 32'h200, '0, 1'b0));
		tbl.push_back(lsu_step("rd_d1", OP_READ, 32'h204, '0, 1'b0));
		tbl.push_back(lsu_step("rd_top", OP_READ, 32'h3fc, '0, 1'b0));
		tbl.push_back(lsu_step("rd_oob", OP_READ, 32'h400, '0, 1'b0));
		tbl.push_back(lsu_step("rd_no_alias", OP_READ, 32'h000, '0, 1'b0));
		tbl.push_back(fetch_step("f_to_prog", 3'b010, 32'h3f0, 32'h100, 32'h3f4, 1'b0));
		tbl.push_back(fetch_step("f_seq_lw", 3'b000, '0, '0, '0, 1'b0));
		tbl.push_back(fetch_step("f_seq_sw", 3'b000, '0, '0, '0, 1'b0));
		tbl.push_back(fetch_step("f_seq_slli_f7", 3'b000, '0, '0, '0, 1'b1));
		tbl.push_back(fetch_step("f_seq_jalr_f3", 3'b000, '0, '0, '0, 1'b1));
		tbl.push_back(fetch_step("f_seq_ecall", 3'b000, '0, '0, '0, 1'b0));
		tbl.push_back(fetch_step("f_seq_mret", 3'b000, '0, '0, '0, 1'b0));
		tbl.push_back(fetch_step("f_seq_bad_opc", 3'b000, '0, '0, '0, 1'b1));
		tbl.push_back(fetch_step("f_seq_srai", 3'b000, '0, '0, '0, 1'b0));
		tbl.push_back(fetch_step("f_branch", 3'b001, 32'h12c, 32'h12c, 32'h128, 1'b0));
		tbl.push_back(fetch_step("f_jump_over_br", 3'b011, 32'h12c, 32'h124, 32'h12c, 1'b0));
		tbl.push_back(fetch_step("f_trap_over_all", 3'b111, 32'h118, 32'h100, 32'h104, 1'b0));
		tbl.push_back(fetch_step("f_trap_over_br", 3'b101, 32'h12c, 32'h100, 32'h100, 1'b1));
		tbl.push_back(fetch_step("f_fault", 3'b010, '0, 32'h800, '0, 1'b0));
		tbl.push_back(fetch_step("f_fault_seq", 3'b000, '0, '0, '0, 1'b0));
		tbl.push_back(fetch_step("f_recover", 3'b001, '0, '0, 32'h100, 1'b0));
		// load/store strobe together with a fetch
		tbl.push_back(mix_step("mix_rd", OP_MIX_RD, 32'h204, 1'b0));
		tbl.push_back(mix_step("mix_wr", OP_MIX_WR, 32'h208, 1'b0));
		tbl.push_back(lsu_step("rd_mix", OP_READ, 32'h208, '0, 1'b0));
		foreach (tbl[i])
			if (tbl[i].rand_data)
				tbl[i].data = $urandom();
	endtask

	// byte address below the end of memory
	function automatic logic in_mem(rv_isa_pkg::addr_t a);
		return a < 32'(4 * mem_bus_pkg::MEM_WORDS);
	endfunction

	function automatic mem_bus_pkg::data_t model_read(rv_isa_pkg::addr_t a);
		if (in_mem(a))
			return model_mem[a[31:2]];
		return '0;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic clear_inputs();
		last_finish_i = 1'b0;
		branch_taken_i = 1'b0;
		branch_target_i = '0;
		jump_i = 1'b0;
		jump_target_i = '0;
		trap_i = 1'b0;
		trap_pc_i = '0;
		lsu_req_i = 1'b0;
		lsu_we_i = 1'b0;
		lsu_addr_i = '0;
		lsu_wdata_i = '0;
	endtask

	task automatic stop_run();
		$display("tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
		if (act !== exp) begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic drive_finish(step_t s);
		last_finish_i = 1'b1;
		trap_i = s.redir[2];
		jump_i = s.redir[1];
		branch_taken_i = s.redir[0];
		trap_pc_i = s.trap_pc;
		jump_target_i = s.jump_pc;
		branch_target_i = s.br_pc;
		// trap first, then jump, then branch, else next word
		if (s.redir[2])
			model_pc = s.trap_pc;
		else if (s.redir[1])
			model_pc = s.jump_pc;
		else if (s.redir[0])
			model_pc = s.br_pc;
		else
			model_pc = model_pc + 32'd4;
	endtask

	task automatic drive_lsu(step_t s, logic we);
		lsu_req_i = 1'b1;
		lsu_we_i = we;
		lsu_addr_i = s.addr;
		lsu_wdata_i = s.data;
		if (we && in_mem(s.addr))
			model_mem[s.addr[31:2]] = s.data;
	endtask

	task automatic check_fetch(step_t s);
		check_eq({s.name, " pc"}, model_pc, pc_o);
		check_eq({s.name, " inst"}, model_read(model_pc), inst_o);
		check_eq({s.name, " illegal"}, s.illegal, inst_illegal_o);
		check_eq({s.name, " fault"}, !in_mem(model_pc), inst_fault_o);
	endtask

	task automatic check_lsu(step_t s, logic we);
		check_eq({s.name, " err"}, !in_mem(s.addr), lsu_err_o);
		if (!we)
			check_eq({s.name, " rdata"}, model_read(s.addr), lsu_rdata_o);
	endtask

	task automatic run_step(step_t s);
		logic we;
		logic got_inst;
		logic got_lsu;
		we = (s.op == OP_WRITE) || (s.op == OP_MIX_WR);
		got_inst = 1'b0;
		got_lsu = 1'b0;
		case (s.op)
			OP_FIRST: begin
				do next_cycle(); while (!inst_valid_o);
				check_fetch(s);
			end
			OP_WRITE, OP_READ: begin
				drive_lsu(s, we);
				next_cycle();
				clear_inputs();
				do next_cycle(); while (!lsu_done_o);
				check_lsu(s, we);
			end
			default: begin
				// core finish arrives after a random delay
				repeat ($urandom_range(4)) next_cycle();
				drive_finish(s);
				if (s.op != OP_FETCH)
					drive_lsu(s, we);
				got_lsu = (s.op == OP_FETCH);
				next_cycle();
				clear_inputs();
				while (!(got_inst && got_lsu)) begin
					next_cycle();
					if (inst_valid_o) begin
						check_fetch(s);
						got_inst = 1'b1;
					end
					if (lsu_done_o && !got_lsu) begin
						check_lsu(s, we);
						got_lsu = 1'b1;
					end
				end
			end
		endcase
	endtask

	initial begin
		int limit;
		int assert_fails;
		void'($urandom(49541));
		clear_inputs();
		build_table();
		foreach (model_mem[i])
			model_mem[i] = '0;
		model_pc = rv_isa_pkg::RESET_PC;
		limit = tbl.size() * CYCLES_PER_STEP + RESET_CYCLES;
		fork
			begin
				repeat (limit) @(posedge clk);
				$display("timeout: the DUT did not respond within %0d cycles", limit);
				stop_run();
			end
		join_none
		wait (rst === 1'b1);
		wait (rst === 1'b0);
		foreach (tbl[i])
			run_step(tbl[i]);
		repeat (4) next_cycle();
		assert_fails = dut_i.arbiter_i.arb_chk_i.fail_cnt +
			dut_i.fetch_unit_i.ifu_chk_i.fail_cnt;
		if (assert_fails == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("%0d concurrent assertion failures", assert_fails);
			stop_run();
		end
	end

endmodule

/* files.f */
rtl/rv_isa_pkg.sv
rtl/mem_bus_pkg.sv
rtl/inst_legal_chk.sv
rtl/fetch_unit.sv
rtl/load_store_unit.sv
rtl/bus_arbiter.sv
rtl/word_sram.sv
rtl/fetch_mem_top.sv
sim/tb_clk_gen.sv
sim/fetch_mem_asserts.sv
sim/fetch_mem_tb.sv

/* Bender.yml */
package:
  name: fetch_mem

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/mem_bus_pkg.sv
  - rtl/inst_legal_chk.sv
  - rtl/fetch_unit.sv
  - rtl/load_store_unit.sv
  - rtl/bus_arbiter.sv
  - rtl/word_sram.sv
  - rtl/fetch_mem_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/fetch_mem_asserts.sv
      - sim/fetch_mem_tb.sv
